// ==== src/nn_cfg_pkg.sv ====
package nn_cfg_pkg;

	// Datapath geometry
	localparam int LANES = 4;
	localparam int WORD_W = 16;
	localparam int ACC_W = 32;
	localparam int ADDR_W = 30;

	// Command field widths
	localparam int OP_W = 3;
	localparam int OPNUM_W = 16;
	localparam int KERN_W = 8;

	// Wide enough to hold a count of LANES
	localparam int CNT_W = 3;

	// Layer op codes
	localparam logic [OP_W-1:0] OP_CONV = 3'd1;
	localparam logic [OP_W-1:0] OP_MPOOL = 3'd4;

endpackage

// ==== src/nn_stream_pkg.sv ====
package nn_stream_pkg;
	import nn_cfg_pkg::*;

	// Layer command, held by the controller for the whole layer
	typedef struct packed {
		logic [OP_W-1:0] op;
		logic [OPNUM_W-1:0] op_num; // Output points
		logic [KERN_W-1:0] kernel; // Beats per point
		logic [ADDR_W-1:0] data_addr;
		logic [ADDR_W-1:0] weight_addr;
		logic [ADDR_W-1:0] result_addr;
	} layer_cmd_t;

	// One deserialized beat
	typedef struct packed {
		logic [LANES-1:0][WORD_W-1:0] data;
		logic [LANES-1:0][WORD_W-1:0] weight;
	} lane_beat_t;

	// Per-lane sums, or sign-extended maxima in maxpool
	typedef struct packed {
		logic [LANES-1:0][ACC_W-1:0] acc;
	} lane_result_t;

	// Words for the DMA write port
	typedef struct packed {
		logic [LANES-1:0][WORD_W-1:0] word;
		logic [CNT_W-1:0] count;
	} wb_packet_t;

endpackage

// ==== src/engine_ctrl.sv ====
module engine_ctrl import nn_cfg_pkg::*, nn_stream_pkg::*; (
	input  logic clk,
	input  logic rst,
	input  logic i_engine_valid,
	input  layer_cmd_t i_cmd,
	input  logic i_beat_strobe,
	input  logic i_busy,
	input  logic i_word_done,
	output layer_cmd_t o_cmd,
	output logic o_p2_reads_en,
	output logic o_p3_reads_en,
	output logic [ADDR_W-1:0] o_p2_addr,
	output logic [ADDR_W-1:0] o_p3_addr,
	output logic [ADDR_W-1:0] o_p0_addr,
	output logic o_engine_ready
);
	typedef enum logic [1:0] {S_IDLE, S_RUN, S_DONE} state_t;

	state_t state;
	logic [OPNUM_W+KERN_W-1:0] beats_total;
	logic [OPNUM_W+KERN_W-1:0] beats_req;
	logic [KERN_W-1:0] k_cnt;
	logic [OPNUM_W-1:0] pts_done;
	logic wait_pt; // Window fully read, point not yet written back
	logic busy_q;
	logic pt_done;
	logic can_req;

	assign beats_total = o_cmd.op_num * o_cmd.kernel;
	assign pt_done = busy_q & ~i_busy;
	assign can_req = (state == S_RUN) && !o_p2_reads_en && !wait_pt && !i_busy &&
		(beats_req < beats_total);

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= S_IDLE;
			o_cmd <= '0;
			o_p2_reads_en <= 1'b0;
			o_p3_reads_en <= 1'b0;
			o_p2_addr <= '0;
			o_p3_addr <= '0;
			o_p0_addr <= '0;
			o_engine_ready <= 1'b0;
			beats_req <= '0;
			k_cnt <= '0;
			pts_done <= '0;
			wait_pt <= 1'b0;
			busy_q <= 1'b0;
		end else begin
			busy_q <= i_busy;
			case (state)
				S_IDLE, S_DONE: begin
					if (i_engine_valid) begin
						o_cmd <= i_cmd;
						o_p2_addr <= i_cmd.data_addr;
						o_p3_addr <= i_cmd.weight_addr;
						o_p0_addr <= i_cmd.result_addr;
						o_engine_ready <= 1'b0;
						beats_req <= '0;
						k_cnt <= '0;
						pts_done <= '0;
						wait_pt <= 1'b0;
						state <= S_RUN;
					end
				end
				S_RUN: begin
					if (can_req) begin
						o_p2_reads_en <= 1'b1;
						o_p3_reads_en <= (o_cmd.op == OP_CONV); // Weights only for conv
					end
					// Beat complete, close the burst and step to the next one
					if (i_beat_strobe) begin
						o_p2_reads_en <= 1'b0;
						o_p3_reads_en <= 1'b0;
						o_p2_addr <= o_p2_addr + ADDR_W'(LANES);
						if (o_cmd.op == OP_CONV)
							o_p3_addr <= o_p3_addr + ADDR_W'(LANES);
						beats_req <= beats_req + 1'b1;
						if (k_cnt == KERN_W'(o_cmd.kernel - 1'b1)) begin
							k_cnt <= '0;
							wait_pt <= 1'b1; // Hold reads until write-back drains
						end else begin
							k_cnt <= k_cnt + 1'b1;
						end
					end
					if (i_word_done)
						o_p0_addr <= o_p0_addr + 1'b1;
					if (pt_done) begin
						wait_pt <= 1'b0;
						pts_done <= pts_done + 1'b1;
						if (pts_done + 1'b1 == o_cmd.op_num) begin
							o_engine_ready <= 1'b1;
							state <= S_DONE;
						end
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

endmodule

// ==== src/burst_deser.sv ====
module burst_deser import nn_cfg_pkg::*, nn_stream_pkg::*; (
	input  logic clk,
	input  logic rst,
	input  layer_cmd_t i_cmd,
	input  logic [WORD_W-1:0] i_p2_ob_data,
	input  logic i_p2_ob_we,
	input  logic [WORD_W-1:0] i_p3_ob_data,
	input  logic i_p3_ob_we,
	output lane_beat_t o_beat,
	output logic o_beat_strobe
);
	logic [CNT_W-1:0] d_cnt;
	logic [CNT_W-1:0] w_cnt;
	logic [CNT_W-1:0] d_nxt;
	logic [CNT_W-1:0] w_nxt;
	logic conv;
	logic w_we;
	logic full;

	assign conv = (i_cmd.op == OP_CONV);
	assign w_we = conv & i_p3_ob_we; // Weight port idle in maxpool
	assign d_nxt = d_cnt + CNT_W'(i_p2_ob_we);
	assign w_nxt = w_cnt + CNT_W'(w_we);

	// Data burst done, and weight burst too for conv
	assign full = (d_nxt == CNT_W'(LANES)) && (!conv || (w_nxt == CNT_W'(LANES)));

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			d_cnt <= '0;
			w_cnt <= '0;
			o_beat_strobe <= 1'b0;
		end else begin
			o_beat_strobe <= full;
			if (full) begin
				d_cnt <= '0;
				w_cnt <= '0;
			end else begin
				d_cnt <= d_nxt;
				w_cnt <= w_nxt;
			end
		end
	end

	// Words land straight in their lane
	always_ff @(posedge clk) begin
		if (i_p2_ob_we)
			o_beat.data[d_cnt] <= i_p2_ob_data;
		if (w_we)
			o_beat.weight[w_cnt] <= i_p3_ob_data;
	end

endmodule

// ==== src/lane_mac.sv ====
module lane_mac import nn_cfg_pkg::*, nn_stream_pkg::*; (
	input  logic clk,
	input  logic rst,
	input  layer_cmd_t i_cmd,
	input  lane_beat_t i_beat,
	input  logic i_beat_strobe,
	output lane_result_t o_res,
	output logic o_res_strobe
);
	logic [KERN_W-1:0] k_cnt;
	logic first;
	logic last;
	logic pool;
	lane_result_t res_nxt;

	assign pool = (i_cmd.op == OP_MPOOL);
	assign first = (k_cnt == '0);
	assign last = (k_cnt == KERN_W'(i_cmd.kernel - 1'b1));

	always_comb begin
		logic signed [ACC_W-1:0] prod;
		logic signed [ACC_W-1:0] val;
		logic signed [ACC_W-1:0] cur;
		res_nxt = o_res;
		for (int l = 0; l < LANES; l++) begin
			prod = $signed(i_beat.data[l]) * $signed(i_beat.weight[l]);
			val = $signed(i_beat.data[l]); // Sign-extend for the compare
			cur = first ? '0 : $signed(o_res.acc[l]); // New window starts clean
			if (pool)
				res_nxt.acc[l] = (first || val > cur) ? val : cur;
			else
				res_nxt.acc[l] = cur + prod;
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			k_cnt <= '0;
			o_res_strobe <= 1'b0;
		end else begin
			o_res_strobe <= i_beat_strobe & last;
			if (i_beat_strobe)
				k_cnt <= last ? '0 : k_cnt + 1'b1;
		end
	end

	// Accumulator doubles as the result register
	always_ff @(posedge clk) begin
		if (i_beat_strobe)
			o_res <= res_nxt;
	end

endmodule

// ==== src/point_reduce.sv ====
module point_reduce import nn_cfg_pkg::*, nn_stream_pkg::*; (
	input  logic clk,
	input  logic rst,
	input  layer_cmd_t i_cmd,
	input  lane_result_t i_res,
	input  logic i_res_strobe,
	output wb_packet_t o_pkt,
	output logic o_pkt_strobe
);
	logic signed [ACC_W-1:0] sum;
	logic [WORD_W-1:0] sat;
	wb_packet_t pkt_nxt;

	always_comb begin
		sum = '0;
		for (int l = 0; l < LANES; l++)
			sum = sum + $signed(i_res.acc[l]);
	end

	// Upper bits not all equal to the sign means out of 16-bit range
	always_comb begin
		if (sum[ACC_W-1:WORD_W-1] == '0 || sum[ACC_W-1:WORD_W-1] == '1)
			sat = sum[WORD_W-1:0];
		else if (sum[ACC_W-1])
			sat = {1'b1, {(WORD_W-1){1'b0}}};
		else
			sat = {1'b0, {(WORD_W-1){1'b1}}};
	end

	always_comb begin
		pkt_nxt = '0;
		if (i_cmd.op == OP_CONV) begin
			pkt_nxt.word[0] = sat;
			pkt_nxt.count = CNT_W'(1);
		end else begin
			for (int l = 0; l < LANES; l++)
				pkt_nxt.word[l] = i_res.acc[l][WORD_W-1:0]; // Maxima fit in a word
			pkt_nxt.count = CNT_W'(LANES);
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			o_pkt_strobe <= 1'b0;
		else
			o_pkt_strobe <= i_res_strobe;
	end

	always_ff @(posedge clk) begin
		if (i_res_strobe)
			o_pkt <= pkt_nxt;
	end

endmodule

// ==== src/writeback_ser.sv ====
module writeback_ser import nn_cfg_pkg::*, nn_stream_pkg::*; (
	input  logic clk,
	input  logic rst,
	input  wb_packet_t i_pkt,
	input  logic i_pkt_strobe,
	input  logic i_p0_ib_re,
	output logic o_p0_writes_en,
	output logic [WORD_W-1:0] o_p0_ib_data,
	output logic o_p0_ib_valid,
	output logic o_busy,
	output logic o_word_done
);
	wb_packet_t pkt_q;
	logic [CNT_W-1:0] idx;
	logic send;

	assign send = o_busy & i_p0_ib_re;
	assign o_p0_writes_en = o_busy; // Request the port while words remain

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			o_busy <= 1'b0;
			o_p0_ib_valid <= 1'b0;
			o_word_done <= 1'b0;
			idx <= '0;
		end else begin
			o_p0_ib_valid <= send;
			o_word_done <= send;
			if (i_pkt_strobe) begin
				o_busy <= 1'b1;
				idx <= '0;
			end else if (send) begin
				if (idx == pkt_q.count - 1'b1) begin
					o_busy <= 1'b0; // Last word of the point
					idx <= '0;
				end else begin
					idx <= idx + 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (i_pkt_strobe)
			pkt_q <= i_pkt;
		if (send)
			o_p0_ib_data <= pkt_q.word[idx];
	end

endmodule

// ==== src/engine.sv ====
module engine import nn_cfg_pkg::*, nn_stream_pkg::*; (
	input  logic clk,
	input  logic rst,
	input  logic i_engine_valid,
	input  logic [OP_W-1:0] i_op,
	input  logic [OPNUM_W-1:0] i_op_num,
	input  logic [KERN_W-1:0] i_kernel,
	input  logic [ADDR_W-1:0] i_data_start_addr,
	input  logic [ADDR_W-1:0] i_weight_start_addr,
	input  logic [ADDR_W-1:0] i_result_start_addr,
	output logic o_engine_ready,
	output logic o_p2_reads_en,
	output logic [ADDR_W-1:0] o_p2_addr,
	input  logic [WORD_W-1:0] i_p2_ob_data,
	input  logic i_p2_ob_we,
	output logic o_p3_reads_en,
	output logic [ADDR_W-1:0] o_p3_addr,
	input  logic [WORD_W-1:0] i_p3_ob_data,
	input  logic i_p3_ob_we,
	output logic o_p0_writes_en,
	output logic [ADDR_W-1:0] o_p0_addr,
	input  logic i_p0_ib_re,
	output logic [WORD_W-1:0] o_p0_ib_data,
	output logic o_p0_ib_valid
);
	layer_cmd_t cmd_in;
	layer_cmd_t cmd;
	lane_beat_t beat;
	lane_result_t res;
	wb_packet_t pkt;
	logic beat_strobe;
	logic res_strobe;
	logic pkt_strobe;
	logic busy;
	logic word_done;

	assign cmd_in = '{op: i_op, op_num: i_op_num, kernel: i_kernel,
		data_addr: i_data_start_addr, weight_addr: i_weight_start_addr,
		result_addr: i_result_start_addr};

	engine_ctrl u_ctrl (
		.clk(clk), .rst(rst), .i_engine_valid(i_engine_valid), .i_cmd(cmd_in),
		.i_beat_strobe(beat_strobe), .i_busy(busy), .i_word_done(word_done),
		.o_cmd(cmd), .o_p2_reads_en(o_p2_reads_en), .o_p3_reads_en(o_p3_reads_en),
		.o_p2_addr(o_p2_addr), .o_p3_addr(o_p3_addr), .o_p0_addr(o_p0_addr),
		.o_engine_ready(o_engine_ready)
	);

	burst_deser u_deser (
		.clk(clk), .rst(rst), .i_cmd(cmd),
		.i_p2_ob_data(i_p2_ob_data), .i_p2_ob_we(i_p2_ob_we),
		.i_p3_ob_data(i_p3_ob_data), .i_p3_ob_we(i_p3_ob_we),
		.o_beat(beat), .o_beat_strobe(beat_strobe)
	);

	lane_mac u_mac (
		.clk(clk), .rst(rst), .i_cmd(cmd), .i_beat(beat), .i_beat_strobe(beat_strobe),
		.o_res(res), .o_res_strobe(res_strobe)
	);

	point_reduce u_reduce (
		.clk(clk), .rst(rst), .i_cmd(cmd), .i_res(res), .i_res_strobe(res_strobe),
		.o_pkt(pkt), .o_pkt_strobe(pkt_strobe)
	);

	writeback_ser u_wb (
		.clk(clk), .rst(rst), .i_pkt(pkt), .i_pkt_strobe(pkt_strobe),
		.i_p0_ib_re(i_p0_ib_re), .o_p0_writes_en(o_p0_writes_en),
		.o_p0_ib_data(o_p0_ib_data), .o_p0_ib_valid(o_p0_ib_valid),
		.o_busy(busy), .o_word_done(word_done)
	);

endmodule

// ==== bench/engine_sva.sv ====
module engine_sva (
	input logic clk,
	input logic rst,
	input logic i_engine_valid,
	input logic i_p0_ib_re,
	input logic o_p0_writes_en,
	input logic o_p0_ib_valid,
	input logic o_p2_reads_en,
	input logic o_p3_reads_en,
	input logic busy,
	input logic o_engine_ready
);

	// A word leaves only after a granted read request
	assert property (@(posedge clk) disable iff (rst)
		o_p0_ib_valid |-> $past(i_p0_ib_re && o_p0_writes_en))
		else $error("write valid without a read request on the previous cycle");

	// No new bursts while write-back drains
	assert property (@(posedge clk) disable iff (rst)
		busy |-> !o_p2_reads_en && !o_p3_reads_en)
		else $error("read enable high while write-back is busy");

	assert property (@(posedge clk) disable iff (rst)
		o_engine_ready && !i_engine_valid |=> o_engine_ready)
		else $error("engine ready dropped without a new command");

	assert property (@(posedge clk) disable iff (rst)
		i_engine_valid |=> !o_engine_ready)
		else $error("engine ready still high after a new command");

endmodule

bind engine engine_sva u_sva (
	.clk(clk), .rst(rst), .i_engine_valid(i_engine_valid), .i_p0_ib_re(i_p0_ib_re),
	.o_p0_writes_en(o_p0_writes_en), .o_p0_ib_valid(o_p0_ib_valid),
	.o_p2_reads_en(o_p2_reads_en), .o_p3_reads_en(o_p3_reads_en), .busy(busy),
	.o_engine_ready(o_engine_ready)
);

// ==== bench/engine_tb.sv ====
module engine_tb import nn_cfg_pkg::*; ();

	localparam int SEED = 6479;
	localparam int DRIVE_DLY = 10;
	localparam int MEM_DEPTH = 1024;
	// Op_num times kernel of every layer in the run
	localparam int BEATS_ALL = 1*1 + 4*3 + 2*1 + 3*2 + 3*2 + 2*1 + 2*1 + 2*2;
	localparam int CYCLE_LIMIT = BEATS_ALL * (LANES + 4) * 4 + 200;

	logic clk;
	logic rst;
	logic i_engine_valid;
	logic [OP_W-1:0] i_op;
	logic [OPNUM_W-1:0] i_op_num;
	logic [KERN_W-1:0] i_kernel;
	logic [ADDR_W-1:0] i_data_start_addr;
	logic [ADDR_W-1:0] i_weight_start_addr;
	logic [ADDR_W-1:0] i_result_start_addr;
	logic o_engine_ready;
	logic o_p2_reads_en;
	logic [ADDR_W-1:0] o_p2_addr;
	logic [WORD_W-1:0] i_p2_ob_data;
	logic i_p2_ob_we;
	logic o_p3_reads_en;
	logic [ADDR_W-1:0] o_p3_addr;
	logic [WORD_W-1:0] i_p3_ob_data;
	logic i_p3_ob_we;
	logic o_p0_writes_en;
	logic [ADDR_W-1:0] o_p0_addr;
	logic i_p0_ib_re;
	logic [WORD_W-1:0] o_p0_ib_data;
	logic o_p0_ib_valid;

	logic [WORD_W-1:0] data_mem [0:MEM_DEPTH-1];
	logic [WORD_W-1:0] weight_mem [0:MEM_DEPTH-1];
	logic [WORD_W-1:0] exp_word [$];
	logic [WORD_W-1:0] got_word [$];
	logic [ADDR_W-1:0] got_addr [$];
	logic [ADDR_W-1:0] exp_p2_addr;
	logic [ADDR_W-1:0] exp_p3_addr;
	logic [OP_W-1:0] cur_op;
	logic re_grant; // Read request on a requested write port, due at the next edge
	string cur_test;
	int d_idx;
	int w_idx;
	int bursts;
	int re_gap_pct;
	int cycle_cnt;
	int mismatch_cnt;
	int fail_cnt;
	int seed_val;

	engine UUT (.*);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_cnt++;
		if (cycle_cnt > CYCLE_LIMIT) begin
			$display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("ERRORS FOUND");
			$finish;
		end
	end

	// DMA model, records the write port and serves LANES words per read burst
	always @(posedge clk) begin
		#DRIVE_DLY;
		if (o_p0_ib_valid !== re_grant) begin
			$display("%s: write valid is %b after a write port grant of %b", cur_test,
				o_p0_ib_valid, re_grant);
			fail_cnt++;
		end
		if (o_p0_ib_valid) begin
			got_word.push_back(o_p0_ib_data);
			got_addr.push_back(o_p0_addr); // Address still points at this word
		end
		i_p0_ib_re = ($urandom_range(0, 99) >= re_gap_pct);
		re_grant = i_p0_ib_re && o_p0_writes_en;
		if (o_p2_reads_en) begin
			if (d_idx == 0) begin
				check_addr({cur_test, " p2"}, exp_p2_addr, o_p2_addr);
				exp_p2_addr = exp_p2_addr + ADDR_W'(LANES);
				bursts++;
			end
			i_p2_ob_we = (d_idx < LANES);
			if (d_idx < LANES)
				i_p2_ob_data = data_mem[int'(o_p2_addr) + d_idx];
			d_idx++;
		end else begin
			i_p2_ob_we = 1'b0;
			d_idx = 0;
		end
		if (o_p3_reads_en) begin
			if (cur_op != OP_CONV) begin
				$display("%s: weight port enabled outside conv", cur_test);
				fail_cnt++;
			end
			if (w_idx == 0) begin
				check_addr({cur_test, " p3"}, exp_p3_addr, o_p3_addr);
				exp_p3_addr = exp_p3_addr + ADDR_W'(LANES);
			end
			i_p3_ob_we = (w_idx < LANES);
			if (w_idx < LANES)
				i_p3_ob_data = weight_mem[int'(o_p3_addr) + w_idx];
			w_idx++;
		end else begin
			i_p3_ob_we = 1'b0;
			w_idx = 0;
		end
	end

	task automatic check_word(input string name, input logic [WORD_W-1:0] exp,
		input logic [WORD_W-1:0] act);
		if (act !== exp) begin
			$display("mismatch %s word: expected %0d, actual %0d", name, $signed(exp),
				$signed(act));
			mismatch_cnt++;
		end
	endtask

	task automatic check_addr(input string name, input logic [ADDR_W-1:0] exp,
		input logic [ADDR_W-1:0] act);
		if (act !== exp) begin
			$display("mismatch %s addr: expected 0x%0h, actual 0x%0h", name, exp, act);
			mismatch_cnt++;
		end
	endtask

	task automatic check_done(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("mismatch %s done: expected %b, actual %b", name, exp, act);
			mismatch_cnt++;
		end
	endtask

	task automatic fill_random(input int daddr, input int waddr, input int n, input int span);
		for (int i = 0; i < n; i++) begin
			data_mem[daddr + i] = WORD_W'($urandom_range(0, 2 * span - 1) - span);
			weight_mem[waddr + i] = WORD_W'($urandom_range(0, 2 * span - 1) - span);
		end
	endtask

	// Sum of data times weight over the window, clamped to a signed word
	function automatic logic [WORD_W-1:0] conv_point(input int daddr, input int waddr,
		input int kernel, input int p);
		longint sum;
		int a;
		int d;
		int w;
		sum = 0;
		for (int b = 0; b < kernel; b++) begin
			for (int l = 0; l < LANES; l++) begin
				a = (p * kernel + b) * LANES + l;
				d = $signed(data_mem[daddr + a]);
				w = $signed(weight_mem[waddr + a]);
				sum += longint'(d * w);
			end
		end
		if (sum > 32767)
			return 16'h7fff;
		if (sum < -32768)
			return 16'h8000;
		return WORD_W'(sum);
	endfunction

	function automatic logic [WORD_W-1:0] pool_word(input int daddr, input int kernel,
		input int p, input int l);
		int best;
		int d;
		best = -32769; // Below any 16-bit value
		for (int b = 0; b < kernel; b++) begin
			d = $signed(data_mem[daddr + (p * kernel + b) * LANES + l]);
			if (d > best)
				best = d;
		end
		return WORD_W'(best);
	endfunction

	task automatic run_layer(input string name, input logic [OP_W-1:0] op, input int op_num,
		input int kernel, input int daddr, input int waddr, input int raddr);
		cur_test = name;
		cur_op = op;
		exp_p2_addr = ADDR_W'(daddr);
		exp_p3_addr = ADDR_W'(waddr);
		bursts = 0;
		got_word.delete();
		got_addr.delete();
		@(posedge clk);
		#DRIVE_DLY;
		i_engine_valid = 1'b1;
		i_op = op;
		i_op_num = OPNUM_W'(op_num);
		i_kernel = KERN_W'(kernel);
		i_data_start_addr = ADDR_W'(daddr);
		i_weight_start_addr = ADDR_W'(waddr);
		i_result_start_addr = ADDR_W'(raddr);
		@(posedge clk);
		#DRIVE_DLY;
		i_engine_valid = 1'b0;
		check_done(name, 1'b0, o_engine_ready); // Cleared by the command
		while (!o_engine_ready) begin
			@(posedge clk);
			#DRIVE_DLY;
		end
		if (o_p0_writes_en !== 1'b0) begin
			$display("%s: write port still requested after the layer is done", name);
			fail_cnt++;
		end
		if (bursts != op_num * kernel) begin
			$display("%s: %0d read bursts instead of %0d", name, bursts, op_num * kernel);
			fail_cnt++;
		end
		if (got_word.size() != exp_word.size()) begin
			$display("%s: %0d words written instead of %0d", name, got_word.size(),
				exp_word.size());
			fail_cnt++;
		end
		for (int i = 0; i < exp_word.size() && i < got_word.size(); i++) begin
			check_word(name, exp_word[i], got_word[i]);
			check_addr(name, ADDR_W'(raddr + i), got_addr[i]);
		end
		exp_word.delete();
	endtask

	task automatic test_conv(input string name, input int op_num, input int kernel,
		input int daddr, input int waddr, input int raddr);
		fill_random(daddr, waddr, op_num * kernel * LANES, 64);
		for (int p = 0; p < op_num; p++)
			exp_word.push_back(conv_point(daddr, waddr, kernel, p));
		run_layer(name, OP_CONV, op_num, kernel, daddr, waddr, raddr);
	endtask

	task automatic test_maxpool(input string name, input int op_num, input int kernel,
		input int daddr, input int raddr);
		fill_random(daddr, daddr, op_num * kernel * LANES, 32768);
		for (int p = 0; p < op_num; p++)
			for (int l = 0; l < LANES; l++)
				exp_word.push_back(pool_word(daddr, kernel, p, l));
		run_layer(name, OP_MPOOL, op_num, kernel, daddr, 0, raddr);
	endtask

	task automatic test_saturation();
		for (int l = 0; l < LANES; l++) begin
			data_mem[80 + l] = 16'd200;
			data_mem[84 + l] = -16'sd200;
			weight_mem[700 + l] = 16'd100;
			weight_mem[704 + l] = 16'd100;
		end
		exp_word.push_back(16'h7fff); // +80000 clamps
		exp_word.push_back(16'h8000); // -80000 clamps
		run_layer("saturation", OP_CONV, 2, 1, 80, 700, 200);
	endtask

	task automatic test_backpressure();
		re_gap_pct = 60;
		test_conv("backpressure conv", 3, 2, 200, 800, 400);
		test_maxpool("backpressure maxpool", 2, 1, 240, 420);
		re_gap_pct = 0;
	endtask

	task automatic test_done_restart();
		test_maxpool("restart first", 2, 1, 300, 500);
		repeat (3) @(posedge clk);
		#DRIVE_DLY;
		check_done("restart hold", 1'b1, o_engine_ready);
		test_conv("restart second", 2, 2, 320, 900, 520);
	endtask

	initial begin
		seed_val = $urandom(SEED);
		rst = 1'b1;
		i_engine_valid = 1'b0;
		i_op = '0;
		i_op_num = '0;
		i_kernel = '0;
		i_data_start_addr = '0;
		i_weight_start_addr = '0;
		i_result_start_addr = '0;
		i_p2_ob_data = '0;
		i_p2_ob_we = 1'b0;
		i_p3_ob_data = '0;
		i_p3_ob_we = 1'b0;
		i_p0_ib_re = 1'b0;
		re_grant = 1'b0;
		re_gap_pct = 0;
		cur_test = "reset";
		cur_op = OP_CONV;
		repeat (2) @(posedge clk);
		#DRIVE_DLY;
		rst = 1'b0;
		check_done("reset", 1'b0, o_engine_ready);
		test_conv("conv single", 1, 1, 0, 512, 0);
		test_conv("conv windows", 4, 3, 16, 600, 100);
		test_saturation();
		test_maxpool("maxpool", 3, 2, 128, 300);
		test_backpressure();
		test_done_restart();
		$display("mismatches: %0d, other errors: %0d", mismatch_cnt, fail_cnt);
		if (mismatch_cnt + fail_cnt == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

// ==== tb.f ====
src/nn_cfg_pkg.sv
src/nn_stream_pkg.sv
src/engine_ctrl.sv
src/burst_deser.sv
src/lane_mac.sv
src/point_reduce.sv
src/writeback_ser.sv
src/engine.sv
bench/engine_sva.sv
bench/engine_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= engine_tb
FILELIST ?= tb.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -Wno-fatal -j 0

SRCS := $(shell grep -v '^+' $(FILELIST))
SIM := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	@./$(SIM) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "ERRORS FOUND" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
